// File: project.f
+incdir+tb
verilog/io_pkg.sv
verilog/io_bus_if.sv
verilog/io_decode.sv
verilog/ms_timer.sv
verilog/io_ctrl_regs.sv
verilog/io_read_mux.sv
verilog/io_block.sv
tb/io_block_tb.sv

// File: tb/io_block_tests.svh
// Directed tests for the I/O register block
// Included into the testbench module

task automatic test_reset_state;
    @(negedge clk_cpu);
    check_led("led_o", led_o, '0);
    check_ss("spi_ss_n_o", spi_ss_n_o, 2'b11);
    check_bit("spi_fast_o", spi_fast_o, 1'b0);
    check_bit("flush_o", flush_o, 1'b0);
    check_bit("uart_rx_done_o", uart_rx_done_o, 1'b0);
    check_word("fb_addr_o", fb_addr_o, io_pkg::DEFAULT_FB_ADDRESS);
    bus_read(io_addr(io_pkg::REG_FB_ADDR));
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, io_pkg::DEFAULT_FB_ADDRESS);
    bus_idle();
endtask

task automatic test_ctrl_regs;
    io_pkg::word_t led_w;
    io_pkg::word_t spi_w;
    io_pkg::word_t fb_w;
    led_w = take_bits(32);
    spi_w = take_bits(32);
    fb_w  = take_bits(32);
    bus_write(io_addr(io_pkg::REG_LED), led_w, 1'b1);
    @(negedge clk_cpu);
    check_led("led_o", led_o, '0);  // Still the reset value
    bus_write(io_addr(io_pkg::REG_SPI_CTRL), spi_w, 1'b1);
    @(negedge clk_cpu);
    check_led("led_o", led_o, led_w[7:0]);
    bus_write(io_addr(io_pkg::REG_FB_ADDR), fb_w, 1'b1);
    @(negedge clk_cpu);
    check_ss("spi_ss_n_o", spi_ss_n_o, ~spi_w[1:0]);
    check_bit("spi_fast_o", spi_fast_o, spi_w[2]);
    bus_read(io_addr(io_pkg::REG_FB_ADDR));
    @(negedge clk_cpu);
    check_word("fb_addr_o", fb_addr_o, fb_w);
    check_word("rdata_o", rdata_o, fb_w);
    // Writes without the clock enable leave every register alone
    bus_write(io_addr(io_pkg::REG_LED), ~led_w, 1'b0);
    bus_write(io_addr(io_pkg::REG_SPI_CTRL), ~spi_w, 1'b0);
    bus_write(io_addr(io_pkg::REG_FB_ADDR), ~fb_w, 1'b0);
    bus_idle();
    @(negedge clk_cpu);
    check_led("led_o", led_o, led_w[7:0]);
    check_ss("spi_ss_n_o", spi_ss_n_o, ~spi_w[1:0]);
    check_bit("spi_fast_o", spi_fast_o, spi_w[2]);
    check_word("fb_addr_o", fb_addr_o, fb_w);
endtask

task automatic test_uart;
    io_pkg::word_t tx_w;
    io_pkg::byte_t rx_b;
    logic [1:0]    rdy;
    int            cycles;
    tx_w = take_bits(32);
    rx_b = io_pkg::byte_t'(take_bits(8));
    bus_write(io_addr(io_pkg::REG_UART_DATA), tx_w, 1'b1);
    @(negedge clk_cpu);
    check_bit("uart_tx_start_o", uart_tx_start_o, 1'b1);
    check_byte("uart_tx_data_o", uart_tx_data_o, tx_w[7:0]);
    bus_read(io_addr(io_pkg::REG_UART_DATA));
    uart_rx_data_i = rx_b;
    @(negedge clk_cpu);
    check_bit("uart_tx_start_o", uart_tx_start_o, 1'b0);
    check_word("rdata_o", rdata_o, {24'b0, rx_b});
    check_bit("uart_rx_done_o", uart_rx_done_o, 1'b0);
    bus_idle();
    await_pulse(1'b0, cycles);
    if (cycles != 0) begin
        $display("uart_rx_done_o rose %0d cycles late after the read", cycles);
        abort_run();
    end
    next_cycle();
    @(negedge clk_cpu);
    check_bit("uart_rx_done_o", uart_rx_done_o, 1'b0);  // One cycle only
    for (int i = 0; i < 4; i++) begin
        rdy = 2'(i);
        bus_read(io_addr(io_pkg::REG_UART_STAT));
        uart_tx_rdy_i = rdy[1];
        uart_rx_rdy_i = rdy[0];
        @(negedge clk_cpu);
        check_word("rdata_o", rdata_o, {30'b0, rdy});
    end
    bus_idle();
endtask

task automatic test_spi;
    io_pkg::word_t spi_w;
    spi_w = take_bits(32);
    bus_write(io_addr(io_pkg::REG_SPI_DATA), take_bits(32), 1'b1);
    @(negedge clk_cpu);
    check_bit("spi_start_o", spi_start_o, 1'b1);
    check_bit("uart_tx_start_o", uart_tx_start_o, 1'b0);
    bus_read(io_addr(io_pkg::REG_SPI_DATA));
    spi_rx_data_i = spi_w;
    @(negedge clk_cpu);
    check_bit("spi_start_o", spi_start_o, 1'b0);
    check_word("rdata_o", rdata_o, spi_w);
    bus_read(io_addr(io_pkg::REG_SPI_CTRL));
    spi_rdy_i = 1'b1;
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, 32'h1);
    bus_read(io_addr(io_pkg::REG_SPI_CTRL));
    spi_rdy_i = 1'b0;
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, 32'h0);
    bus_idle();
endtask

task automatic test_timer;
    io_pkg::word_t start_ms;
    bus_read(io_addr(io_pkg::REG_MS));
    @(negedge clk_cpu);
    start_ms = rdata_o;
    repeat (3 * io_pkg::CLKS_PER_MS) @(negedge clk_cpu);  // Exactly three milliseconds
    check_word("rdata_o", rdata_o, start_ms + 32'd3);
    bus_idle();
endtask

task automatic test_misc;
    io_pkg::word_t cache_w;
    io_pkg::addr_t mem_adr;
    int            cycles;
    cache_w = take_bits(32) | 32'h1;
    bus_write(io_addr(io_pkg::REG_CACHE), cache_w, 1'b1);
    @(negedge clk_cpu);
    check_bit("flush_o", flush_o, 1'b0);
    bus_idle();
    await_pulse(1'b1, cycles);
    if (cycles != 0) begin
        $display("flush_o rose %0d cycles late after the cache write", cycles);
        abort_run();
    end
    next_cycle();
    @(negedge clk_cpu);
    check_bit("flush_o", flush_o, 1'b0);
    bus_write(io_addr(io_pkg::REG_CACHE), cache_w & ~32'h1, 1'b1);
    bus_idle();
    @(negedge clk_cpu);
    check_bit("flush_o", flush_o, 1'b0);  // Bit 0 clear requests nothing
    bus_read(io_addr(io_pkg::REG_HW_CFG));
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, 32'h8000_0000);
    bus_read(io_addr(5'd7));
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, 32'h0);
    bus_read(io_addr(io_pkg::REG_CACHE));
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, 32'h0);
    mem_adr        = take_bits(32);
    mem_adr[31:28] = 4'h2;  // Any region but the I/O one
    bus_read(mem_adr);
    mem_rdata_i = take_bits(32);
    @(negedge clk_cpu);
    check_word("rdata_o", rdata_o, mem_rdata_i);
    bus_idle();
endtask

// File: tb/io_block_tb.sv
// Testbench for the I/O register block
// Clock, reset, bus access helpers and compare tasks around the DUT
module io_block_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PULSE_TIMEOUT = 20;  // Cycles allowed for a pulse to show up

    logic              clk_cpu;
    logic              rst_n;
    io_pkg::addr_t     adr_i;
    logic              rd_i;
    logic              wr_i;
    logic              ce_i;
    io_pkg::word_t     wdata_i;
    io_pkg::word_t     mem_rdata_i;
    io_pkg::word_t     rdata_o;
    io_pkg::byte_t     uart_rx_data_i;
    logic              uart_rx_rdy_i;
    logic              uart_tx_rdy_i;
    logic              uart_rx_done_o;
    logic              uart_tx_start_o;
    io_pkg::byte_t     uart_tx_data_o;
    io_pkg::word_t     spi_rx_data_i;
    logic              spi_rdy_i;
    logic              spi_start_o;
    io_pkg::ss_n_t     spi_ss_n_o;
    logic              spi_fast_o;
    io_pkg::led_t      led_o;
    io_pkg::addr_t     fb_addr_o;
    logic              flush_o;
    logic [15:0]       lfsr;

    io_block dut (.*);

    initial begin
        clk_cpu = 1'b0;
        forever #10 clk_cpu = ~clk_cpu;  // 50 MHz bench clock
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per bit taken, first bit lands in the MSB of the result
    function automatic io_pkg::word_t take_bits(input int n);
        io_pkg::word_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic io_pkg::addr_t io_addr(input io_pkg::reg_idx_t idx);
        return {io_pkg::IO_REGION, 21'b0, idx, 2'b00};
    endfunction

    task automatic abort_run;
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input io_pkg::word_t got,
                              input io_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input io_pkg::byte_t got,
                              input io_pkg::byte_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_led(input string name, input io_pkg::led_t got,
                             input io_pkg::led_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ss(input string name, input io_pkg::ss_n_t got,
                            input io_pkg::ss_n_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_cycle;
        @(posedge clk_cpu);
        #2;  // Drive point after the edge
    endtask

    task automatic bus_write(input io_pkg::addr_t adr, input io_pkg::word_t data,
                             input logic ce);
        next_cycle();
        adr_i   = adr;
        wdata_i = data;
        ce_i    = ce;
        rd_i    = 1'b0;
        wr_i    = 1'b1;
    endtask

    task automatic bus_read(input io_pkg::addr_t adr);
        next_cycle();
        adr_i = adr;
        ce_i  = 1'b1;
        wr_i  = 1'b0;
        rd_i  = 1'b1;
    endtask

    task automatic bus_idle;
        next_cycle();
        rd_i = 1'b0;
        wr_i = 1'b0;
        ce_i = 1'b1;
    endtask

    // Counts mid-cycle samples until the pulse is seen, zero means the first one
    task automatic await_pulse(input logic on_flush, output int cycles);
        string name;
        name   = on_flush ? "flush_o" : "uart_rx_done_o";
        cycles = 0;
        @(negedge clk_cpu);
        while (!(on_flush ? flush_o : uart_rx_done_o)) begin
            if (cycles >= PULSE_TIMEOUT) begin
                $display("Timeout: %s did not rise within %0d cycles", name, PULSE_TIMEOUT);
                abort_run();
            end
            cycles++;
            @(negedge clk_cpu);
        end
    endtask

    `include "io_block_tests.svh"

    initial begin
        lfsr           = 16'd33560;
        rst_n          = 1'b1;  // Reset asserted
        adr_i          = '0;
        rd_i           = 1'b0;
        wr_i           = 1'b0;
        ce_i           = 1'b1;
        wdata_i        = '0;
        mem_rdata_i    = '0;
        uart_rx_data_i = '0;
        uart_rx_rdy_i  = 1'b0;
        uart_tx_rdy_i  = 1'b0;
        spi_rx_data_i  = '0;
        spi_rdy_i      = 1'b0;
        repeat (16) @(posedge clk_cpu);
        #2;
        rst_n = 1'b0;
        test_reset_state();
        test_ctrl_regs();
        test_uart();
        test_spi();
        test_timer();
        test_misc();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verilog/io_block.sv
// Memory-mapped I/O register block
// Decodes the 0xE region and holds the timer, LED, UART, SPI and framebuffer registers
module io_block (
    input  wire logic          clk_cpu,
    input  wire logic          rst_n,
    // Processor access
    input  wire io_pkg::addr_t adr_i,
    input  wire logic          rd_i,
    input  wire logic          wr_i,
    input  wire logic          ce_i,
    input  wire io_pkg::word_t wdata_i,
    input  wire io_pkg::word_t mem_rdata_i,
    output io_pkg::word_t      rdata_o,
    // UART engine
    input  wire io_pkg::byte_t uart_rx_data_i,
    input  wire logic          uart_rx_rdy_i,
    input  wire logic          uart_tx_rdy_i,
    output logic               uart_rx_done_o,
    output logic               uart_tx_start_o,
    output io_pkg::byte_t      uart_tx_data_o,
    // SPI engine
    input  wire io_pkg::word_t spi_rx_data_i,
    input  wire logic          spi_rdy_i,
    output logic               spi_start_o,
    output io_pkg::ss_n_t      spi_ss_n_o,
    output logic               spi_fast_o,
    // Board and memory system
    output io_pkg::led_t       led_o,
    output io_pkg::addr_t      fb_addr_o,
    output logic               flush_o
);

    io_bus_if          bus ();
    io_pkg::ms_count_t ms_count;

    io_decode u_decode (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .adr_i   (adr_i),
        .rd_i    (rd_i),
        .wr_i    (wr_i),
        .ce_i    (ce_i),
        .wdata_i (wdata_i),
        .bus     (bus.decoder)
    );

    ms_timer u_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    io_ctrl_regs u_ctrl_regs (
        .bus             (bus.target),
        .clk_cpu         (clk_cpu),
        .rst_n           (rst_n),
        .led_o           (led_o),
        .spi_ss_n_o      (spi_ss_n_o),
        .spi_fast_o      (spi_fast_o),
        .fb_addr_o       (fb_addr_o),
        .flush_o         (flush_o),
        .uart_tx_start_o (uart_tx_start_o),
        .uart_tx_data_o  (uart_tx_data_o),
        .spi_start_o     (spi_start_o)
    );

    io_read_mux u_read_mux (
        .bus            (bus.target),
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .ms_count_i     (ms_count),
        .mem_rdata_i    (mem_rdata_i),
        .uart_rx_data_i (uart_rx_data_i),
        .uart_rx_rdy_i  (uart_rx_rdy_i),
        .uart_tx_rdy_i  (uart_tx_rdy_i),
        .spi_rx_data_i  (spi_rx_data_i),
        .spi_rdy_i      (spi_rdy_i),
        .led_i          (led_o),      // Register outputs fed back for readback
        .fb_addr_i      (fb_addr_o),
        .rdata_o        (rdata_o),
        .uart_rx_done_o (uart_rx_done_o)
    );

endmodule

// File: verilog/io_bus_if.sv
// Decoded I/O access, one per cycle, from the decoder to the register targets
interface io_bus_if;

    logic               io_sel;   // Address lies in the I/O region
    io_pkg::reg_idx_t   reg_idx;  // Word index inside the region
    logic               rd;       // Read strobe
    logic               wr;       // Write strobe
    logic               ce;       // Processor clock enable
    io_pkg::word_t      wdata;    // Write data

    modport decoder (
        output io_sel,
        output reg_idx,
        output rd,
        output wr,
        output ce,
        output wdata
    );

    modport target (
        input  io_sel,
        input  reg_idx,
        input  rd,
        input  wr,
        input  ce,
        input  wdata
    );

endinterface

// File: verilog/io_ctrl_regs.sv
// I/O write side
// LED, SPI control and framebuffer registers, flush request and start pulses
module io_ctrl_regs (
    io_bus_if.target          bus,
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    output io_pkg::led_t      led_o,
    output io_pkg::ss_n_t     spi_ss_n_o,
    output logic              spi_fast_o,
    output io_pkg::addr_t     fb_addr_o,
    output logic              flush_o,
    output logic              uart_tx_start_o,
    output io_pkg::byte_t     uart_tx_data_o,
    output logic              spi_start_o
);

    logic          io_wr;     // Write strobe inside the I/O region
    logic          reg_wr;    // Same, qualified by the clock enable
    io_pkg::led_t  led;
    logic [2:0]    spi_ctrl;  // Fast bit and the two selects; bit 3 has no function
    io_pkg::addr_t fb_addr;
    logic          flush;

    assign io_wr  = bus.wr && bus.io_sel;
    assign reg_wr = io_wr && bus.ce;

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            led      <= '0;
            spi_ctrl <= '0;
            fb_addr  <= io_pkg::DEFAULT_FB_ADDRESS;
            flush    <= 1'b0;
        end else begin
            flush <= 1'b0;  // Single-cycle request
            if (reg_wr) begin
                case (bus.reg_idx)
                    io_pkg::REG_LED:      led      <= bus.wdata[7:0];
                    io_pkg::REG_SPI_CTRL: spi_ctrl <= bus.wdata[2:0];
                    io_pkg::REG_FB_ADDR:  fb_addr  <= bus.wdata;
                    io_pkg::REG_CACHE:    flush    <= bus.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    assign led_o      = led;
    assign spi_ss_n_o = ~spi_ctrl[1:0];  // Active low selects
    assign spi_fast_o = spi_ctrl[2];
    assign fb_addr_o  = fb_addr;
    assign flush_o    = flush;

    // Start pulses are combinational in the write cycle
    assign uart_tx_start_o = io_wr && (bus.reg_idx == io_pkg::REG_UART_DATA);
    assign uart_tx_data_o  = bus.wdata[7:0];
    assign spi_start_o     = io_wr && (bus.reg_idx == io_pkg::REG_SPI_DATA);

    // The cache controller takes one flush per request. Two back-to-back
    // requests would mean the processor wrote REG_CACHE in consecutive cycles.
    flush_single_cycle: assert property (
        @(posedge clk_cpu) disable iff (rst_n)
        flush_o |=> !flush_o
    ) else $error("io_ctrl_regs: flush held for two cycles");

endmodule

// File: verilog/io_decode.sv
// I/O address decoder
// Claims the 0xE region and presents the word index and strobes on the I/O bus
module io_decode (
    input  wire logic          clk_cpu,
    input  wire logic          rst_n,
    input  wire io_pkg::addr_t adr_i,
    input  wire logic          rd_i,
    input  wire logic          wr_i,
    input  wire logic          ce_i,
    input  wire io_pkg::word_t wdata_i,
    io_bus_if.decoder          bus
);

    logic              region_hit;
    io_pkg::reg_idx_t  word_idx;

    assign region_hit = (adr_i[31:28] == io_pkg::IO_REGION);
    assign word_idx   = adr_i[6:2];  // Byte offset dropped

    assign bus.io_sel  = region_hit;
    assign bus.reg_idx = word_idx;
    assign bus.rd      = rd_i;
    assign bus.wr      = wr_i;
    assign bus.ce      = ce_i;
    assign bus.wdata   = wdata_i;

    // The processor issues either a read or a write in one cycle, never both.
    // Both targets rely on this when they decode the strobes.
    rd_wr_exclusive: assert property (
        @(posedge clk_cpu) disable iff (rst_n)
        !(rd_i && wr_i)
    ) else $error("io_decode: read and write strobes high together");

endmodule

// File: verilog/io_pkg.sv
// I/O register block shared definitions
// Bus widths, register map, clock rate and reset values
package io_pkg;

    typedef logic [31:0] word_t;      // Processor data word
    typedef logic [31:0] addr_t;      // Processor byte address
    typedef logic [4:0]  reg_idx_t;   // I/O word index, address bits 6..2
    typedef logic [7:0]  byte_t;      // UART data
    typedef logic [7:0]  led_t;       // LED pattern
    typedef logic [1:0]  ss_n_t;      // SPI slave selects, active low
    typedef logic [31:0] ms_count_t;  // Milliseconds since reset
    typedef logic [16:0] prescale_t;  // Clocks within one millisecond

    localparam logic [3:0] IO_REGION = 4'hE;  // Matched against address bits 31..28

    localparam int FREQ_HZ     = 25_000_000;
    localparam int CLKS_PER_MS = FREQ_HZ / 1000;

    localparam addr_t DEFAULT_FB_ADDRESS = 32'h0100_0000;

    // Bit 31 of the hardware configuration word, cleared for synthesis builds
    localparam logic IS_SIMULATION = 1'b1;

    // Register map, one word per index
    localparam reg_idx_t REG_MS        = 5'd0;   // Milliseconds / --
    localparam reg_idx_t REG_LED       = 5'd1;   // -- / LEDs
    localparam reg_idx_t REG_UART_DATA = 5'd2;   // Rx data / Tx data and start
    localparam reg_idx_t REG_UART_STAT = 5'd3;   // Tx and rx ready / --
    localparam reg_idx_t REG_SPI_DATA  = 5'd4;   // Rx data / Tx start
    localparam reg_idx_t REG_SPI_CTRL  = 5'd5;   // SPI ready / selects and speed
    localparam reg_idx_t REG_CACHE     = 5'd9;   // -- / flush request
    localparam reg_idx_t REG_FB_ADDR   = 5'd10;  // Framebuffer base
    localparam reg_idx_t REG_HW_CFG    = 5'd14;  // Configuration word / --

endpackage

// File: verilog/io_read_mux.sv
// I/O read side
// Selects register read data or memory data, and acknowledges UART receive reads
module io_read_mux (
    io_bus_if.target              bus,
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    input  wire io_pkg::ms_count_t ms_count_i,
    input  wire io_pkg::word_t     mem_rdata_i,
    input  wire io_pkg::byte_t     uart_rx_data_i,
    input  wire logic              uart_rx_rdy_i,
    input  wire logic              uart_tx_rdy_i,
    input  wire io_pkg::word_t     spi_rx_data_i,
    input  wire logic              spi_rdy_i,
    input  wire io_pkg::led_t      led_i,
    input  wire io_pkg::addr_t     fb_addr_i,
    output io_pkg::word_t          rdata_o,
    output logic                   uart_rx_done_o
);

    io_pkg::word_t io_rdata;
    logic          rx_done;

    always_comb begin
        io_rdata = '0;
        case (bus.reg_idx)
            io_pkg::REG_MS:        io_rdata = ms_count_i;
            io_pkg::REG_LED:       io_rdata = '0;  // LEDs are write-only
            io_pkg::REG_UART_DATA: io_rdata = {24'b0, uart_rx_data_i};
            io_pkg::REG_UART_STAT: io_rdata = {30'b0, uart_tx_rdy_i, uart_rx_rdy_i};
            io_pkg::REG_SPI_DATA:  io_rdata = spi_rx_data_i;
            io_pkg::REG_SPI_CTRL:  io_rdata = {31'b0, spi_rdy_i};
            io_pkg::REG_FB_ADDR:   io_rdata = fb_addr_i;
            io_pkg::REG_HW_CFG:    io_rdata = {io_pkg::IS_SIMULATION, 31'b0};
            default:               io_rdata = '0;  // Unused or dropped index
        endcase
    end

    assign rdata_o = bus.io_sel ? io_rdata : mem_rdata_i;

    // Tells the UART receiver its byte was taken
    always_ff @(posedge clk_cpu) begin
        if (rst_n)
            rx_done <= 1'b0;
        else
            rx_done <= bus.rd && bus.io_sel && (bus.reg_idx == io_pkg::REG_UART_DATA);
    end

    assign uart_rx_done_o = rx_done;

endmodule

// File: verilog/ms_timer.sv
// Millisecond timer
// Prescaler divides the CPU clock down to one tick per millisecond
module ms_timer (
    input  wire logic         clk_cpu,
    input  wire logic         rst_n,
    output io_pkg::ms_count_t ms_count_o
);

    io_pkg::prescale_t prescale;
    io_pkg::ms_count_t ms_count;
    logic              limit;  // Last clock of the current millisecond

    assign limit = (prescale == io_pkg::prescale_t'(io_pkg::CLKS_PER_MS - 1));

    always_ff @(posedge clk_cpu) begin
        if (rst_n) begin
            prescale <= '0;
            ms_count <= '0;
        end else begin
            prescale <= limit ? '0 : prescale + 1'b1;
            if (limit)
                ms_count <= ms_count + 1'b1;  // Visible the cycle after the wrap
        end
    end

    assign ms_count_o = ms_count;

    prescale_in_range: assert property (
        @(posedge clk_cpu) disable iff (rst_n)
        prescale <= io_pkg::prescale_t'(io_pkg::CLKS_PER_MS - 1)
    ) else $error("ms_timer: prescaler past its limit");

endmodule
